//--- tb.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_mem.sv
hw/icache.sv
verification/imem_model.sv
verification/tb_icache.sv

//--- Makefile
# Verilator build for the instruction cache testbench

VERILATOR  ?= verilator
TOP        ?= tb_icache
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "sim: failure reported, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "sim: run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_icache.sv
`default_nettype none
`timescale 1ns/1ps

module tb_icache;

  import icache_pkg::*;

  localparam int unsigned clock_period     = 10;
  localparam int unsigned fetch_bound      = 40;   // Longest a single miss may take
  localparam int unsigned random_fetches   = 300;
  localparam int unsigned directed_fetches = 30;
  localparam int unsigned watchdog_cycles  =
    (random_fetches + directed_fetches) * (fetch_bound + 2) + 200;

  logic       clock;
  logic       reset;
  addr_t      fetch_addr;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  word_t      fetch_data;
  logic       fetch_valid;
  logic       busy;
  logic [3:0] latency;

  logic       resident_valid [32];   // Lines the testbench expects to hit
  cache_tag_t resident_tag   [32];

  int unsigned checks;
  int unsigned errors;
  int unsigned tests;
  int unsigned test_first_error;

  icache icache_inst (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_rsp     (mem_rsp),
    .mem_req     (mem_req),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid)
  );

  imem_model imem_inst (
    .clock   (clock),
    .reset   (reset),
    .busy    (busy),
    .latency (latency),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // ##########################################################################
  // Reference and compare tasks
  // ##########################################################################

  function automatic word_t mem_word(input addr_t addr);
    addr_t aligned;
    aligned = {addr[63:3], 3'b000};
    return ~{aligned[31:0], aligned[63:32]};   // Halves swapped, then inverted
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic check_cmd(input string name, input bus_cmd_e got, input bus_cmd_e expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR %s at %0t", msg, $time);
  endtask

  task automatic finish_test(input string name);
    int unsigned found;
    found = errors - test_first_error;
    tests++;
    $display("test %-14s done with %0d errors", name, found);
    test_first_error = errors;
  endtask

  // Every valid word and every load address is compared while the outputs are steady
  always @(negedge clock) begin
    if (!reset) begin
      if (fetch_valid) begin
        check_word("fetch_data", fetch_data, mem_word(fetch_addr));
      end
      if (mem_req.command == BUS_LOAD) begin
        check_addr("mem_req.addr", mem_req.addr, fetch_addr & ~addr_t'(7));
      end
    end
  end

  // ##########################################################################
  // One fetch, predicted from the resident lines
  // ##########################################################################

  task automatic run_fetch(input addr_t addr, input logic [3:0] latency_cycles,
                           input int unsigned busy_cycles, output logic hit_now);
    cache_index_t index;
    cache_tag_t   tag;
    logic         expect_hit;
    int unsigned  cycles;
    index      = addr[7:3];
    tag        = addr[15:8];
    expect_hit = resident_valid[index] && (resident_tag[index] == tag);
    cycles     = 0;
    @(posedge clock);
    fetch_addr <= addr;
    latency    <= latency_cycles;
    busy       <= (busy_cycles != 0);
    @(negedge clock);
    hit_now = fetch_valid;
    if (expect_hit) begin
      if (!fetch_valid) begin
        report_failure($sformatf("fetch of %h missed although its line is resident", addr));
      end
      check_cmd("mem_req.command", mem_req.command, BUS_NONE);
    end else begin
      if (fetch_valid) begin
        report_failure($sformatf("fetch of %h hit although its line is not resident", addr));
      end
      while (!fetch_valid && cycles < fetch_bound) begin
        @(posedge clock);
        cycles++;
        busy <= (cycles <= busy_cycles);
        @(negedge clock);
        // The load goes out right after the miss and repeats while memory is busy
        if (cycles == 1 || cycles <= busy_cycles) begin
          check_cmd("mem_req.command", mem_req.command, BUS_LOAD);
        end
      end
      if (!fetch_valid) begin
        report_failure($sformatf("fetch of %h never completed in %0d cycles", addr, cycles));
      end else begin
        if (cycles < 3) begin
          report_failure($sformatf("miss on %h completed after only %0d cycles", addr, cycles));
        end
        resident_valid[index] = 1'b1;
        resident_tag[index]   = tag;
      end
    end
  endtask

  // ##########################################################################
  // Test sequence
  // ##########################################################################

  initial begin
    addr_t       addr;
    logic        hit_now;
    logic        accepted;
    int unsigned waited;
    int unsigned n;
    void'($urandom(32'h415e_9562));
    reset            = 1'b1;
    fetch_addr       = '0;
    busy             = 1'b0;
    latency          = '0;
    checks           = 0;
    errors           = 0;
    tests            = 0;
    test_first_error = 0;
    for (n = 0; n < 32; n++) begin
      resident_valid[n] = 1'b0;
      resident_tag[n]   = '0;
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    run_fetch(64'h123d, 4'd2, 0, hit_now);   // Unaligned on purpose
    finish_test("cold miss");

    run_fetch(64'h1240, 4'd1, 0, hit_now);
    for (n = 0; n < 8; n++) begin
      addr = (n % 2 == 1) ? 64'h1240 + addr_t'(n) : 64'h1238 + addr_t'(n);
      run_fetch(addr, 4'd1, 0, hit_now);
    end
    finish_test("repeated hits");

    run_fetch(64'h2310, 4'd2, 0, hit_now);
    run_fetch(64'h4510, 4'd2, 0, hit_now);   // Same index with another tag
    run_fetch(64'h2310, 4'd2, 0, hit_now);
    if (hit_now) begin
      report_failure("address 2310 still hit after its line was replaced");
    end
    finish_test("conflict");

    run_fetch(64'h3a08, 4'd3, 5, hit_now);
    finish_test("busy memory");

    // Wait until the load is accepted, then move away while its data is pending
    @(posedge clock);
    fetch_addr <= 64'h5518;
    latency    <= 4'd3;
    busy       <= 1'b0;
    accepted = 1'b0;
    waited   = 0;
    @(negedge clock);
    while (!accepted && waited < fetch_bound) begin
      if (mem_req.command == BUS_LOAD && mem_rsp.response != '0) begin
        accepted = 1'b1;
      end else begin
        @(posedge clock);
        @(negedge clock);
        waited++;
      end
    end
    if (!accepted) begin
      report_failure("load for address 5518 was never accepted");
    end
    run_fetch(64'h6620, 4'd6, 0, hit_now);   // Stale data lands while this one waits
    repeat (12) @(posedge clock);
    run_fetch(64'h5518, 4'd1, 0, hit_now);
    if (hit_now) begin
      report_failure("abandoned address 5518 hit, stale data filled its line");
    end
    finish_test("abandoned miss");

    for (n = 0; n < random_fetches; n++) begin
      addr = addr_t'($urandom_range(16'h03ff, 0));
      run_fetch(addr, 4'($urandom_range(5, 0)),
                ($urandom_range(3, 0) == 0) ? $urandom_range(3, 1) : 0, hit_now);
    end
    finish_test("random stream");

    @(posedge clock);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/imem_model.sv
`default_nettype none
`timescale 1ns/1ps

module imem_model (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 busy,       // Refuse every load while high
  input  logic [3:0]           latency,    // Extra cycles before data of a new load
  input  icache_pkg::mem_req_t mem_req,
  output icache_pkg::mem_rsp_t mem_rsp
);

  import icache_pkg::*;

  // One slot per token, tokens are never reused while outstanding
  logic [15:1] pend_valid;
  addr_t       pend_addr  [1:15];
  logic [3:0]  pend_count [1:15];

  mem_tag_t    next_token;
  mem_tag_t    rsp_tag;
  word_t       rsp_data;

  function automatic word_t word_at(input addr_t addr);
    addr_t line_addr;
    line_addr = {addr[63:3], 3'b000};
    return ~{line_addr[31:0], line_addr[63:32]};
  endfunction

  // ##########################################################################
  // Request side answers in the same cycle
  // ##########################################################################

  assign mem_rsp.response = (mem_req.command == BUS_LOAD && !busy) ? next_token : '0;
  assign mem_rsp.data     = rsp_data;
  assign mem_rsp.tag      = rsp_tag;

  // ##########################################################################
  // Outstanding loads and tagged data
  // ##########################################################################

  always @(posedge clock) begin : step
    logic found;
    int   slot;
    found = 1'b0;
    if (reset) begin
      pend_valid <= '0;
      next_token <= 4'd1;
      rsp_tag    <= '0;
      rsp_data   <= '0;
    end else begin
      rsp_tag <= '0;                          // Data is on the bus for one cycle only
      for (slot = 1; slot < 16; slot++) begin
        if (pend_valid[slot]) begin
          if (pend_count[slot] == 0) begin
            // Loads due together leave one per cycle
            if (!found) begin
              rsp_data         <= word_at(pend_addr[slot]);
              rsp_tag          <= mem_tag_t'(slot);
              pend_valid[slot] <= 1'b0;
              found = 1'b1;
            end
          end else begin
            pend_count[slot] <= pend_count[slot] - 4'd1;
          end
        end
      end
      if (mem_req.command == BUS_LOAD && !busy) begin
        pend_valid[next_token] <= 1'b1;
        pend_addr[next_token]  <= mem_req.addr;
        pend_count[next_token] <= latency;
        next_token <= (next_token == 4'd15) ? 4'd1 : next_token + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/icache.sv
`default_nettype none
`timescale 1ns/1ps

module icache (
  input  logic                 clock,
  input  logic                 reset,
  input  icache_pkg::addr_t    fetch_addr,
  input  icache_pkg::mem_rsp_t mem_rsp,
  output icache_pkg::mem_req_t mem_req,
  output icache_pkg::word_t    fetch_data,
  output logic                 fetch_valid
);

  import icache_pkg::*;

  fill_t fill;        // Controller to storage
  logic  line_hit;    // Storage to controller and processor
  word_t line_data;

  // ##########################################################################
  // Miss controller
  // ##########################################################################

  icache_ctrl ctrl_inst (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .hit        (line_hit),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .fill       (fill)
  );

  // ##########################################################################
  // Line storage
  // ##########################################################################

  icache_mem mem_inst (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .fill       (fill),
    .hit        (line_hit),
    .data       (line_data)
  );

  // The processor sees the storage directly, a miss simply stays invalid until the fill lands
  assign fetch_valid = line_hit;
  assign fetch_data  = line_data;

endmodule

`default_nettype wire

//--- hw/icache_mem.sv
`default_nettype none
`timescale 1ns/1ps

module icache_mem (
  input  logic              clock,
  input  logic              reset,
  input  icache_pkg::addr_t fetch_addr,
  input  icache_pkg::fill_t fill,
  output logic              hit,
  output icache_pkg::word_t data
);

  import icache_pkg::*;

  // ##########################################################################
  // Line storage
  // ##########################################################################

  word_t                  data_lines [cache_lines];
  cache_tag_t             tag_lines  [cache_lines];
  logic [cache_lines-1:0] valid_bits;

  cache_index_t fetch_index;
  cache_tag_t   fetch_tag;

  assign fetch_index = addr_index(fetch_addr);
  assign fetch_tag   = addr_tag(fetch_addr);

  // Read side is purely combinational so a hit answers in the fetch cycle
  assign hit  = valid_bits[fetch_index] && (tag_lines[fetch_index] == fetch_tag);
  assign data = data_lines[fetch_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;                        // Every line starts empty
    end else if (fill.write_enable) begin
      valid_bits[fill.index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill.write_enable) begin
      data_lines[fill.index] <= fill.data;
      tag_lines[fill.index]  <= fill.tag;
    end
  end

  // ##########################################################################
  // Checks
  // ##########################################################################

  // On a steady address a hit only appears right after the fill of that line
  hit_rise_from_fill: assert property (@(posedge clock) disable iff (reset)
    $rose(hit) && $stable(fetch_addr) |->
      $past(fill.write_enable) && ($past(fill.index) == fetch_index) &&
      ($past(fill.tag) == fetch_tag));

endmodule

`default_nettype wire

//--- hw/icache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  icache_pkg::addr_t    fetch_addr,
  input  logic                 hit,
  input  icache_pkg::mem_rsp_t mem_rsp,
  output icache_pkg::mem_req_t mem_req,
  output icache_pkg::fill_t    fill
);

  import icache_pkg::*;

  cache_index_t current_index;
  cache_tag_t   current_tag;
  cache_index_t last_index;
  cache_tag_t   last_tag;
  logic         changed_addr;

  ctrl_state_e  state;
  ctrl_state_e  next_state;
  mem_tag_t     mem_token;    // Token of the load we are waiting on

  logic         send_load;
  logic         token_accepted;
  logic         data_arrived;

  // ##########################################################################
  // Address tracking
  // ##########################################################################

  assign current_index = addr_index(fetch_addr);
  assign current_tag   = addr_tag(fetch_addr);
  assign changed_addr  = (current_index != last_index) || (current_tag != last_tag);

  // All ones out of reset, so the first fetch address looks new
  always_ff @(posedge clock) begin
    if (reset) begin
      last_index <= '1;
      last_tag   <= '1;
    end else begin
      last_index <= current_index;
      last_tag   <= current_tag;
    end
  end

  // ##########################################################################
  // Miss handling
  // ##########################################################################

  assign send_load      = (state == REQUEST) && !changed_addr;
  assign token_accepted = send_load && (mem_rsp.response != '0);
  // Only data tagged with our own token counts, and only for the address it was loaded for
  assign data_arrived   = (state == WAIT_DATA) && !changed_addr && (mem_rsp.tag == mem_token);

  always_comb begin
    next_state = state;
    if (changed_addr) begin
      // A new address drops whatever was in flight
      next_state = hit ? LOOKUP : REQUEST;
    end else begin
      case (state)
        LOOKUP: begin
          if (!hit) begin
            next_state = REQUEST;
          end
        end
        REQUEST: begin
          if (token_accepted) begin
            next_state = WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (data_arrived) begin
            next_state = LOOKUP;
          end
        end
        default: next_state = LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= LOOKUP;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_token <= '0;
    end else if (changed_addr || data_arrived) begin
      mem_token <= '0;                 // Stale data can no longer match
    end else if (token_accepted) begin
      mem_token <= mem_rsp.response;
    end
  end

  // ##########################################################################
  // Outputs
  // ##########################################################################

  // A busy answer leaves the state in REQUEST, so the load repeats next cycle
  assign mem_req.command = send_load ? BUS_LOAD : BUS_NONE;
  assign mem_req.addr    = {fetch_addr[63:3], 3'b000};

  assign fill.write_enable = data_arrived;
  assign fill.index        = current_index;
  assign fill.tag          = current_tag;
  assign fill.data         = mem_rsp.data;

  // Loads go out only while the storage still misses on the requested line
  load_only_on_miss: assert property (@(posedge clock) disable iff (reset)
    (mem_req.command == BUS_LOAD) |-> (state == REQUEST) && !hit);

  // WAIT_DATA is entered only with a real token, so a fill never matches an idle bus
  fill_has_token: assert property (@(posedge clock) disable iff (reset)
    fill.write_enable |-> (mem_token != '0));

endmodule

`default_nettype wire

//--- hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // ##########################################################################
  // Widths and address split
  // ##########################################################################

  typedef logic [63:0] addr_t;
  typedef logic [63:0] word_t;
  typedef logic [4:0]  cache_index_t;  // Address bits 7 to 3
  typedef logic [7:0]  cache_tag_t;    // Address bits 15 to 8
  typedef logic [3:0]  mem_tag_t;      // Zero is never a valid token

  localparam int unsigned cache_lines = 32;

  // The fetch address is split the same way by the controller and the storage
  function automatic cache_index_t addr_index(input addr_t addr);
    return addr[7:3];
  endfunction

  function automatic cache_tag_t addr_tag(input addr_t addr);
    return addr[15:8];
  endfunction

  // ##########################################################################
  // Encodings
  // ##########################################################################

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2   // Kept for the bus format, the cache never stores
  } bus_cmd_e;

  typedef enum logic [1:0] {
    LOOKUP    = 2'h0,
    REQUEST   = 2'h1,
    WAIT_DATA = 2'h2
  } ctrl_state_e;

  // ##########################################################################
  // Bundles
  // ##########################################################################

  typedef struct packed {
    bus_cmd_e command;
    addr_t    addr;       // Always on an 8-byte boundary
  } mem_req_t;

  typedef struct packed {
    mem_tag_t response;   // Token for an accepted load, zero while busy
    word_t    data;
    mem_tag_t tag;        // Token of the load whose data is on the bus
  } mem_rsp_t;

  typedef struct packed {
    logic         write_enable;
    cache_index_t index;
    cache_tag_t   tag;
    word_t        data;
  } fill_t;

endpackage

`default_nettype wire
